// File: hw/priv_pkg.sv
// **************************************************
// Privileged unit package
// Privilege modes, CSR addresses and operations,
// trap cause codes and shared field positions
// **************************************************
package priv_pkg;

    localparam int XLEN = 32;

    typedef enum logic [1:0] {
        U_MODE = 2'b00,
        M_MODE = 2'b11
    } priv_mode_e;

    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_e;

    // PMP address registers follow CSR_PMPADDR0 in order
    typedef enum logic [11:0] {
        CSR_MSTATUS  = 12'h300,
        CSR_MIE      = 12'h304,
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342,
        CSR_MTVAL    = 12'h343,
        CSR_MIP      = 12'h344,
        CSR_PMPCFG0  = 12'h3A0,
        CSR_PMPADDR0 = 12'h3B0
    } csr_addr_e;

    typedef enum logic [3:0] {
        EXC_INSN_MISALIGN  = 4'd0,
        EXC_INSN_FAULT     = 4'd1,
        EXC_ILLEGAL_INSN   = 4'd2,
        EXC_BREAKPOINT     = 4'd3,
        EXC_LOAD_MISALIGN  = 4'd4,
        EXC_LOAD_FAULT     = 4'd5,
        EXC_STORE_MISALIGN = 4'd6,
        EXC_STORE_FAULT    = 4'd7,
        EXC_ECALL_U        = 4'd8,
        EXC_ECALL_M        = 4'd11
    } exc_cause_e;

    typedef enum logic [3:0] {
        INT_M_SOFT  = 4'd3,
        INT_M_TIMER = 4'd7,
        INT_M_EXT   = 4'd11
    } int_cause_e;

    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10
    } acc_width_e;

    // Bit positions in mstatus, mie and mip
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;
    localparam int MSTATUS_MPP  = 11;
    localparam int MSTATUS_TW   = 21;
    localparam int MSI_BIT      = 3;
    localparam int MTI_BIT      = 7;
    localparam int MEI_BIT      = 11;

endpackage

// File: hw/priv_csr.sv
// **************************************************
// Machine CSR file
// Read-write, set and clear access with privilege
// checks, plus trap and mret updates of mstatus
// **************************************************
`timescale 1ns/1ps

module priv_csr import priv_pkg::*; #(
    parameter int PMP_ENTRIES = 4
) (
    input  logic                                CLK,
    input  logic                                reset,
    input  logic                                csr_valid,
    input  csr_op_e                             csr_op,
    input  logic [11:0]                         csr_addr,
    input  logic [XLEN-1:0]                     wdata,
    input  priv_mode_e                          curr_priv,
    input  logic                                trap_take,
    input  logic [3:0]                          trap_cause,
    input  logic                                trap_is_int,
    input  logic [XLEN-1:0]                     trap_epc,
    input  logic [XLEN-1:0]                     trap_tval,
    input  logic                                mret_take,
    input  logic                                timer_int,
    input  logic                                soft_int,
    input  logic                                ext_int,
    output logic [XLEN-1:0]                     rdata,
    output logic                                csr_invalid,
    output logic                                mstatus_mie,
    output logic                                mstatus_mpie,
    output priv_mode_e                          mstatus_mpp,
    output logic                                mstatus_tw,
    output logic [XLEN-1:0]                     mtvec,
    output logic [XLEN-1:0]                     mepc,
    output logic [XLEN-1:0]                     mie,
    output logic [XLEN-1:0]                     mip,
    output logic [XLEN-1:0]                     pmp_cfg,
    output logic [PMP_ENTRIES-1:0][XLEN-1:0]    pmp_addr
);

    logic [XLEN-1:0] mcause, mtval, mscratch, mstatus;
    logic [XLEN-1:0] new_val;
    logic            csr_known, is_write, csr_wen;

    // Only the three machine interrupt bits exist
    localparam logic [XLEN-1:0] MIE_MASK = (1 << MSI_BIT) | (1 << MTI_BIT) | (1 << MEI_BIT);

    assign mip = (XLEN'(ext_int) << MEI_BIT) | (XLEN'(timer_int) << MTI_BIT)
               | (XLEN'(soft_int) << MSI_BIT);

    always_comb begin
        mstatus = '0;
        mstatus[MSTATUS_MIE] = mstatus_mie;
        mstatus[MSTATUS_MPIE] = mstatus_mpie;
        mstatus[MSTATUS_MPP +: 2] = mstatus_mpp;
        mstatus[MSTATUS_TW] = mstatus_tw;
    end

    // Read mux, also tells whether the address exists
    always_comb begin
        csr_known = 1'b1;
        rdata = '0;
        case (csr_addr)
            CSR_MSTATUS:  rdata = mstatus;
            CSR_MIE:      rdata = mie;
            CSR_MTVEC:    rdata = mtvec;
            CSR_MSCRATCH: rdata = mscratch;
            CSR_MEPC:     rdata = mepc;
            CSR_MCAUSE:   rdata = mcause;
            CSR_MTVAL:    rdata = mtval;
            CSR_MIP:      rdata = mip;
            CSR_PMPCFG0:  rdata = pmp_cfg;
            default: begin
                csr_known = 1'b0;
                for (int i = 0; i < PMP_ENTRIES; i++) begin
                    if (csr_addr == 12'(CSR_PMPADDR0 + i)) begin
                        csr_known = 1'b1;
                        rdata = pmp_addr[i];
                    end
                end
            end
        endcase
    end

    always_comb begin
        case (csr_op)
            CSR_RS:  new_val = rdata | wdata;
            CSR_RC:  new_val = rdata & ~wdata;
            default: new_val = wdata;
        endcase
    end

    // Set or clear with a zero mask is a pure read
    assign is_write = (csr_op == CSR_RW) || (wdata != '0);
    assign csr_invalid = csr_valid & (~csr_known | (curr_priv == U_MODE)
                       | ((csr_addr == CSR_MIP) & is_write));
    assign csr_wen = csr_valid & ~csr_invalid;

    always_ff @(posedge CLK) begin
        if (reset) begin
            mstatus_mie <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp <= U_MODE;
            mstatus_tw <= 1'b0;
            mtvec <= '0;
            mepc <= '0;
            mcause <= '0;
            mtval <= '0;
            mie <= '0;
            mscratch <= '0;
            pmp_cfg <= '0;
            pmp_addr <= '0;
        end else if (trap_take) begin
            mepc <= trap_epc;
            mcause <= {trap_is_int, {(XLEN-5){1'b0}}, trap_cause};
            mtval <= trap_tval;
            mstatus_mpie <= mstatus_mie;
            mstatus_mie <= 1'b0;
            mstatus_mpp <= curr_priv;
        end else if (mret_take) begin
            mstatus_mie <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
            mstatus_mpp <= U_MODE;
        end else if (csr_wen) begin
            case (csr_addr)
                CSR_MSTATUS: begin
                    mstatus_mie <= new_val[MSTATUS_MIE];
                    mstatus_mpie <= new_val[MSTATUS_MPIE];
                    // MPP keeps only legal modes
                    mstatus_mpp <= (new_val[MSTATUS_MPP +: 2] == 2'b11) ? M_MODE : U_MODE;
                    mstatus_tw <= new_val[MSTATUS_TW];
                end
                CSR_MIE:      mie <= new_val & MIE_MASK;
                CSR_MTVEC:    mtvec <= {new_val[XLEN-1:2], 2'b00};
                CSR_MSCRATCH: mscratch <= new_val;
                CSR_MEPC:     mepc <= {new_val[XLEN-1:2], 2'b00};
                CSR_MCAUSE:   mcause <= new_val;
                CSR_MTVAL:    mtval <= new_val;
                CSR_PMPCFG0:  pmp_cfg <= new_val;
                default: begin
                    for (int i = 0; i < PMP_ENTRIES; i++) begin
                        if (csr_addr == 12'(CSR_PMPADDR0 + i))
                            pmp_addr[i] <= new_val;
                    end
                end
            endcase
        end
    end

endmodule

// File: hw/priv_pma.sv
// **************************************************
// Physical memory attribute check
// Fixed RAM and IO regions, any other address faults
// **************************************************
`timescale 1ns/1ps

module priv_pma import priv_pkg::*; #(
    parameter logic [XLEN-1:0] RAM_BASE = 32'h8000_0000,
    parameter logic [XLEN-1:0] RAM_SIZE = 32'h0001_0000,
    parameter logic [XLEN-1:0] IO_BASE  = 32'h1000_0000,
    parameter logic [XLEN-1:0] IO_SIZE  = 32'h0000_1000
) (
    input  logic            iren,
    input  logic [XLEN-1:0] iaddr,
    input  logic            dren,
    input  logic            dwen,
    input  logic [XLEN-1:0] daddr,
    input  acc_width_e      d_acc_width,
    output logic            pma_i_fault,
    output logic            pma_l_fault,
    output logic            pma_s_fault
);

    logic i_in_ram, d_in_ram, d_in_io, d_ok;

    // Offset compare wraps below the base, so one test covers both bounds
    assign i_in_ram = (iaddr - RAM_BASE) < RAM_SIZE;
    assign d_in_ram = (daddr - RAM_BASE) < RAM_SIZE;
    assign d_in_io  = (daddr - IO_BASE) < IO_SIZE;

    // IO registers take full words only
    assign d_ok = d_in_ram | (d_in_io & (d_acc_width == ACC_WORD));

    assign pma_i_fault = iren & ~i_in_ram;
    assign pma_l_fault = dren & ~d_ok;
    assign pma_s_fault = dwen & ~d_ok;

endmodule

// File: hw/priv_pmp.sv
// **************************************************
// Physical memory protection check
// TOR entries, lowest matching entry decides
// **************************************************
`timescale 1ns/1ps

module priv_pmp import priv_pkg::*; #(
    parameter int PMP_ENTRIES = 4
) (
    input  priv_mode_e                          curr_priv,
    input  logic [XLEN-1:0]                     pmp_cfg,
    input  logic [PMP_ENTRIES-1:0][XLEN-1:0]    pmp_addr,
    input  logic                                iren,
    input  logic [XLEN-1:0]                     iaddr,
    input  logic                                dren,
    input  logic                                dwen,
    input  logic [XLEN-1:0]                     daddr,
    output logic                                pmp_i_fault,
    output logic                                pmp_l_fault,
    output logic                                pmp_s_fault
);

    // Fields of one pmpcfg byte
    localparam int PMP_R = 0;
    localparam int PMP_W = 1;
    localparam int PMP_X = 2;
    localparam int PMP_L = 7;
    localparam logic [1:0] PMP_TOR = 2'b01;

    function automatic logic pmp_fault(input logic [XLEN-1:0] addr, input int perm);
        logic            hit;
        logic            allow;
        logic            locked;
        logic [XLEN-1:0] word;
        logic [XLEN-1:0] lo;
        logic [7:0]      cfg;
        hit = 1'b0;
        allow = 1'b0;
        locked = 1'b0;
        // pmpaddr holds address bits 33:2
        word = {2'b00, addr[XLEN-1:2]};
        lo = '0;
        for (int i = 0; i < PMP_ENTRIES; i++) begin
            cfg = pmp_cfg[8*i +: 8];
            if (!hit && (cfg[4:3] == PMP_TOR) && (word >= lo) && (word < pmp_addr[i])) begin
                hit = 1'b1;
                allow = cfg[perm];
                locked = cfg[PMP_L];
            end
            lo = pmp_addr[i];
        end
        // Machine mode only sees locked entries
        if (curr_priv == M_MODE)
            return hit & locked & ~allow;
        return ~(hit & allow);
    endfunction

    always_comb begin
        pmp_i_fault = iren & pmp_fault(iaddr, PMP_X);
        pmp_l_fault = dren & pmp_fault(daddr, PMP_R);
        pmp_s_fault = dwen & pmp_fault(daddr, PMP_W);
    end

endmodule

// File: hw/priv_trap.sv
// **************************************************
// Trap unit
// Merges protection faults, exceptions and interrupts,
// holds the privilege mode and the PC redirect
// **************************************************
`timescale 1ns/1ps

module priv_trap import priv_pkg::*; (
    input  logic            CLK,
    input  logic            reset,
    input  logic            pma_i_fault,
    input  logic            pma_l_fault,
    input  logic            pma_s_fault,
    input  logic            pmp_i_fault,
    input  logic            pmp_l_fault,
    input  logic            pmp_s_fault,
    input  logic            iren,
    input  logic [XLEN-1:0] iaddr,
    input  logic            dren,
    input  logic            dwen,
    input  logic [XLEN-1:0] daddr,
    input  logic            illegal_insn,
    input  logic            breakpoint,
    input  logic            ecall,
    input  logic            mal_insn,
    input  logic            mal_l,
    input  logic            mal_s,
    input  logic [XLEN-1:0] epc,
    input  logic [XLEN-1:0] badaddr,
    input  logic            ret,
    input  logic            wfi,
    input  logic            mstatus_mie,
    input  priv_mode_e      mstatus_mpp,
    input  logic            mstatus_tw,
    input  logic [XLEN-1:0] mtvec,
    input  logic [XLEN-1:0] mepc,
    input  logic [XLEN-1:0] mie,
    input  logic [XLEN-1:0] mip,
    input  logic            csr_invalid,
    output priv_mode_e      curr_priv,
    output logic            trap_take,
    output logic [3:0]      trap_cause,
    output logic            trap_is_int,
    output logic [XLEN-1:0] trap_epc,
    output logic [XLEN-1:0] trap_tval,
    output logic            mret_take,
    output logic            invalid_priv_isn,
    output logic            prot_fault_i,
    output logic            prot_fault_l,
    output logic            prot_fault_s,
    output logic            insert_pc,
    output logic [XLEN-1:0] priv_pc,
    output logic            intr
);

    logic [XLEN-1:0] pend;
    logic            int_en;

    assign prot_fault_i = iren & (pma_i_fault | pmp_i_fault);
    assign prot_fault_l = dren & (pma_l_fault | pmp_l_fault);
    assign prot_fault_s = dwen & (pma_s_fault | pmp_s_fault);

    assign invalid_priv_isn = csr_invalid | (ret & (curr_priv != M_MODE))
                            | (wfi & (curr_priv == U_MODE) & mstatus_tw);

    // User mode is always interruptible by machine interrupts
    assign pend = mie & mip;
    assign int_en = (curr_priv == U_MODE) | mstatus_mie;

    always_comb begin
        trap_take = 1'b1;
        trap_is_int = 1'b0;
        trap_cause = EXC_ILLEGAL_INSN;
        trap_tval = '0;
        if (int_en & pend[MEI_BIT]) begin
            trap_is_int = 1'b1;
            trap_cause = INT_M_EXT;
        end else if (int_en & pend[MSI_BIT]) begin
            trap_is_int = 1'b1;
            trap_cause = INT_M_SOFT;
        end else if (int_en & pend[MTI_BIT]) begin
            trap_is_int = 1'b1;
            trap_cause = INT_M_TIMER;
        end else if (mal_insn) begin
            trap_cause = EXC_INSN_MISALIGN;
            trap_tval = badaddr;
        end else if (prot_fault_i) begin
            trap_cause = EXC_INSN_FAULT;
            trap_tval = iaddr;
        end else if (illegal_insn) begin
            trap_cause = EXC_ILLEGAL_INSN;
        end else if (breakpoint) begin
            trap_cause = EXC_BREAKPOINT;
        end else if (ecall) begin
            trap_cause = (curr_priv == M_MODE) ? EXC_ECALL_M : EXC_ECALL_U;
        end else if (mal_l | mal_s) begin
            trap_cause = mal_l ? EXC_LOAD_MISALIGN : EXC_STORE_MISALIGN;
            trap_tval = badaddr;
        end else if (prot_fault_l | prot_fault_s) begin
            trap_cause = prot_fault_l ? EXC_LOAD_FAULT : EXC_STORE_FAULT;
            trap_tval = daddr;
        end else begin
            trap_take = 1'b0;
        end
    end

    assign trap_epc = epc;
    assign mret_take = ret & (curr_priv == M_MODE) & ~trap_take;

    always_ff @(posedge CLK) begin
        if (reset) begin
            curr_priv <= M_MODE;
            insert_pc <= 1'b0;
            intr <= 1'b0;
        end else begin
            if (trap_take)
                curr_priv <= M_MODE;
            else if (mret_take)
                curr_priv <= mstatus_mpp;
            insert_pc <= trap_take | mret_take;
            intr <= trap_take & trap_is_int;
        end
    end

    // Direct mode only, so the base is the whole target
    always_ff @(posedge CLK) begin
        if (trap_take)
            priv_pc <= {mtvec[XLEN-1:2], 2'b00};
        else if (mret_take)
            priv_pc <= mepc;
    end

endmodule

// File: hw/priv_block.sv
// **************************************************
// Privileged unit top level
// Connects CSR file, PMA, PMP and trap unit to the
// pipeline
// **************************************************
`timescale 1ns/1ps

module priv_block import priv_pkg::*; #(
    parameter int              PMP_ENTRIES = 4,
    parameter logic [XLEN-1:0] RAM_BASE    = 32'h8000_0000,
    parameter logic [XLEN-1:0] RAM_SIZE    = 32'h0001_0000,
    parameter logic [XLEN-1:0] IO_BASE     = 32'h1000_0000,
    parameter logic [XLEN-1:0] IO_SIZE     = 32'h0000_1000
) (
    input  logic            CLK,
    input  logic            reset,
    input  logic            csr_valid,
    input  csr_op_e         csr_op,
    input  logic [11:0]     csr_addr,
    input  logic [XLEN-1:0] wdata,
    output logic [XLEN-1:0] rdata,
    output logic            invalid_priv_isn,
    input  logic            iren,
    input  logic [XLEN-1:0] iaddr,
    input  logic            dren,
    input  logic            dwen,
    input  logic [XLEN-1:0] daddr,
    input  acc_width_e      d_acc_width,
    output logic            prot_fault_i,
    output logic            prot_fault_l,
    output logic            prot_fault_s,
    input  logic            illegal_insn,
    input  logic            breakpoint,
    input  logic            ecall,
    input  logic            mal_insn,
    input  logic            mal_l,
    input  logic            mal_s,
    input  logic [XLEN-1:0] epc,
    input  logic [XLEN-1:0] badaddr,
    input  logic            ret,
    input  logic            wfi,
    input  logic            timer_int,
    input  logic            soft_int,
    input  logic            ext_int,
    output logic            insert_pc,
    output logic [XLEN-1:0] priv_pc,
    output logic            intr
);

    priv_mode_e                         curr_priv, mstatus_mpp;
    logic                               mstatus_mie, mstatus_tw, csr_invalid;
    logic [XLEN-1:0]                    mtvec, mepc, mie, mip, pmp_cfg;
    logic [PMP_ENTRIES-1:0][XLEN-1:0]   pmp_addr;
    logic                               trap_take, trap_is_int, mret_take;
    logic [3:0]                         trap_cause;
    logic [XLEN-1:0]                    trap_epc, trap_tval;
    logic pma_i_fault, pma_l_fault, pma_s_fault;
    logic pmp_i_fault, pmp_l_fault, pmp_s_fault;

    // MPIE only matters inside the CSR file
    priv_csr #(.PMP_ENTRIES(PMP_ENTRIES)) csr (
        .CLK, .reset, .csr_valid, .csr_op, .csr_addr, .wdata, .curr_priv,
        .trap_take, .trap_cause, .trap_is_int, .trap_epc, .trap_tval, .mret_take,
        .timer_int, .soft_int, .ext_int, .rdata, .csr_invalid,
        .mstatus_mie, .mstatus_mpie(), .mstatus_mpp, .mstatus_tw,
        .mtvec, .mepc, .mie, .mip, .pmp_cfg, .pmp_addr
    );

    priv_pma #(
        .RAM_BASE(RAM_BASE), .RAM_SIZE(RAM_SIZE), .IO_BASE(IO_BASE), .IO_SIZE(IO_SIZE)
    ) pma (
        .iren, .iaddr, .dren, .dwen, .daddr, .d_acc_width,
        .pma_i_fault, .pma_l_fault, .pma_s_fault
    );

    priv_pmp #(.PMP_ENTRIES(PMP_ENTRIES)) pmp (
        .curr_priv, .pmp_cfg, .pmp_addr, .iren, .iaddr, .dren, .dwen, .daddr,
        .pmp_i_fault, .pmp_l_fault, .pmp_s_fault
    );

    priv_trap trap (
        .CLK, .reset, .pma_i_fault, .pma_l_fault, .pma_s_fault,
        .pmp_i_fault, .pmp_l_fault, .pmp_s_fault, .iren, .iaddr, .dren, .dwen, .daddr,
        .illegal_insn, .breakpoint, .ecall, .mal_insn, .mal_l, .mal_s, .epc, .badaddr,
        .ret, .wfi, .mstatus_mie, .mstatus_mpp, .mstatus_tw, .mtvec, .mepc, .mie, .mip,
        .csr_invalid, .curr_priv, .trap_take, .trap_cause, .trap_is_int, .trap_epc,
        .trap_tval, .mret_take, .invalid_priv_isn, .prot_fault_i, .prot_fault_l,
        .prot_fault_s, .insert_pc, .priv_pc, .intr
    );

endmodule

// File: verif/priv_block_checker.sv
// **************************************************
// Trap unit assertions
// Redirect pulse width, reset state and fault strobes
// **************************************************
`timescale 1ns/1ps

module priv_block_checker import priv_pkg::*; (
    input logic            CLK,
    input logic            reset,
    input logic            ecall,
    input logic            breakpoint,
    input logic            illegal_insn,
    input logic            mal_insn,
    input logic            mal_l,
    input logic            mal_s,
    input logic            ret,
    input logic [XLEN-1:0] mie,
    input logic [XLEN-1:0] mip,
    input logic            insert_pc,
    input logic            intr,
    input logic            iren,
    input logic            dren,
    input logic            dwen,
    input logic            pma_i_fault,
    input logic            pma_l_fault,
    input logic            pma_s_fault,
    input logic            pmp_i_fault,
    input logic            pmp_l_fault,
    input logic            pmp_s_fault,
    input logic            prot_fault_i,
    input logic            prot_fault_l,
    input logic            prot_fault_s
);

    logic cause_seen;

    // Anything that may start a trap or an mret in this cycle
    assign cause_seen = ecall | breakpoint | illegal_insn | mal_insn | mal_l | mal_s | ret
                      | prot_fault_i | prot_fault_l | prot_fault_s | (|(mie & mip));

    // A single cause gives a single redirect cycle
    redirect_one_cycle: assert property (@(posedge CLK) disable iff (reset)
        (insert_pc && !cause_seen) |=> !insert_pc)
        else $error("insert_pc stayed high after a single cause");

    reset_state: assert property (@(posedge CLK) reset |=> (!insert_pc && !intr))
        else $error("insert_pc or intr high after reset");

    // PMA and PMP faults feeding each prot_fault output
    fault_i_strobe: assert property (@(posedge CLK) disable iff (reset)
        (pma_i_fault || pmp_i_fault) |-> iren)
        else $error("instruction fault without iren");
    fault_l_strobe: assert property (@(posedge CLK) disable iff (reset)
        (pma_l_fault || pmp_l_fault) |-> dren)
        else $error("load fault without dren");
    fault_s_strobe: assert property (@(posedge CLK) disable iff (reset)
        (pma_s_fault || pmp_s_fault) |-> dwen)
        else $error("store fault without dwen");

endmodule

bind priv_trap priv_block_checker i_checker (.*);

// File: verif/priv_block_tb.sv
// **************************************************
// Privileged unit testbench
// Replays the command file against the DUT and checks
// CSR reads, protection faults and PC redirects
// **************************************************
`timescale 1ns/1ps

module priv_block_tb import priv_pkg::*; ();

    logic CLK, reset;
    logic csr_valid, iren, dren, dwen;
    csr_op_e csr_op;
    acc_width_e d_acc_width;
    logic [11:0] csr_addr;
    logic [XLEN-1:0] wdata, rdata, iaddr, daddr, epc, badaddr, priv_pc;
    logic invalid_priv_isn, prot_fault_i, prot_fault_l, prot_fault_s;
    logic illegal_insn, breakpoint, ecall, mal_insn, mal_l, mal_s, ret, wfi;
    logic timer_int, soft_int, ext_int, insert_pc, intr;

    int fd, n;
    string line;
    logic [63:0] cmd;
    logic [31:0] a, b, c, d, e;

    priv_block #(
        .PMP_ENTRIES(4), .RAM_BASE(32'h8000_0000), .RAM_SIZE(32'h0001_0000),
        .IO_BASE(32'h1000_0000), .IO_SIZE(32'h0000_1000)
    ) i_dut (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    task automatic stop_run();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
            stop_run();
        end
    endtask

    task automatic release_inputs();
        csr_valid <= 1'b0;
        iren <= 1'b0;
        dren <= 1'b0;
        dwen <= 1'b0;
        illegal_insn <= 1'b0;
        breakpoint <= 1'b0;
        ecall <= 1'b0;
        mal_insn <= 1'b0;
        mal_l <= 1'b0;
        mal_s <= 1'b0;
        ret <= 1'b0;
        wfi <= 1'b0;
        timer_int <= 1'b0;
        soft_int <= 1'b0;
        ext_int <= 1'b0;
        epc <= '0;
        badaddr <= '0;
    endtask

    // Redirect must show up within 8 cycles of the cause
    task automatic wait_redirect(input logic [31:0] exp_pc, input logic exp_intr);
        int cycles;
        cycles = 0;
        @(negedge CLK);
        while (!insert_pc && cycles < 8) begin
            cycles++;
            @(negedge CLK);
        end
        assert (insert_pc) else begin
            $display("Timeout: no insert_pc pulse within 8 cycles at %0t ns", $time);
            stop_run();
        end
        // The pulse belongs in the cycle right after the cause
        assert (cycles == 0) else begin
            $display("insert_pc came %0d cycles late at %0t ns", cycles, $time);
            stop_run();
        end
        check_value("priv_pc", priv_pc, exp_pc);
        check_value("intr", intr, exp_intr);
    endtask

    task automatic expect_no_redirect();
        @(negedge CLK);
        check_value("insert_pc", insert_pc, 1'b0);
    endtask

    task automatic run_command();
        @(posedge CLK);
        release_inputs();
        if (cmd == "csr") begin
            csr_valid <= 1'b1;
            csr_op <= csr_op_e'(a[1:0]);
            csr_addr <= b[11:0];
            wdata <= c;
        end else if (cmd == "access") begin
            iren <= (a == 0);
            dren <= (a == 1);
            dwen <= (a == 2);
            iaddr <= b;
            daddr <= b;
            d_acc_width <= acc_width_e'(c[1:0]);
        end else if (cmd == "exc") begin
            ecall <= (a == 0);
            breakpoint <= (a == 1);
            mal_l <= (a == 2);
            epc <= b;
            badaddr <= c;
        end else if (cmd == "ret") begin
            ret <= 1'b1;
        end else if (cmd == "irq") begin
            ext_int <= a[0];
            timer_int <= b[0];
            soft_int <= c[0];
            epc <= d;
        end else begin
            $display("Unknown command in stimulus file: %s", cmd);
            stop_run();
        end
        @(negedge CLK);
        if (cmd == "csr") begin
            check_value("invalid_priv_isn", invalid_priv_isn, e[0]);
            // Read data only matters for a legal access
            if (!e[0])
                check_value("rdata", rdata, d);
        end else if (cmd == "access") begin
            case (a)
                0: check_value("prot_fault_i", prot_fault_i, d[0]);
                1: check_value("prot_fault_l", prot_fault_l, d[0]);
                default: check_value("prot_fault_s", prot_fault_s, d[0]);
            endcase
        end else if (cmd == "ret") begin
            check_value("invalid_priv_isn", invalid_priv_isn, a[0]);
        end
        @(posedge CLK);
        release_inputs();
        if ((cmd == "access" && d[0]) || cmd == "exc")
            wait_redirect((cmd == "exc") ? d : e, 1'b0);
        else if (cmd == "ret" && !a[0])
            wait_redirect(b, 1'b0);
        else if (cmd == "irq")
            wait_redirect(e, 1'b1);
        else if (cmd != "csr")
            expect_no_redirect();
    endtask

    initial begin
        reset = 1'b1;
        csr_valid = 1'b0;
        csr_op = CSR_RW;
        csr_addr = '0;
        wdata = '0;
        iren = 1'b0;
        iaddr = '0;
        dren = 1'b0;
        dwen = 1'b0;
        daddr = '0;
        d_acc_width = ACC_WORD;
        illegal_insn = 1'b0;
        breakpoint = 1'b0;
        ecall = 1'b0;
        mal_insn = 1'b0;
        mal_l = 1'b0;
        mal_s = 1'b0;
        epc = '0;
        badaddr = '0;
        ret = 1'b0;
        wfi = 1'b0;
        timer_int = 1'b0;
        soft_int = 1'b0;
        ext_int = 1'b0;
        repeat (16) @(posedge CLK);
        reset <= 1'b0;

        fd = $fopen("verif/priv_stimulus.txt", "r");
        assert (fd != 0) else begin
            $display("Could not open the stimulus file verif/priv_stimulus.txt");
            stop_run();
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() == 0 || line.getc(0) == "#")
                continue;
            n = $sscanf(line, "%s %h %h %h %h %h", cmd, a, b, c, d, e);
            if (n < 1)
                continue;
            assert (n == 6) else begin
                $display("Malformed stimulus line: %s", line);
                stop_run();
            end
            run_command();
        end
        $fclose(fd);

        repeat (2) @(posedge CLK);
        $display("Test OK");
        $finish;
    end

endmodule

// File: priv_unit.f
hw/priv_pkg.sv
hw/priv_csr.sv
hw/priv_pma.sv
hw/priv_pmp.sv
hw/priv_trap.sv
hw/priv_block.sv
verif/priv_block_checker.sv
verif/priv_block_tb.sv

// File: verif/priv_stimulus.txt
# cmd    a     b         c         d         e
# csr    op    addr      wdata     exp_rdata exp_invalid   (op 1 rw, 2 set, 3 clear)
# access kind  addr      width     exp_fault exp_pc        (kind 0 fetch, 1 load, 2 store)
# exc    kind  epc       badaddr   exp_pc    0             (kind 0 ecall, 1 ebreak, 2 mal load)
# ret    exp_invalid exp_pc 0 0 0
# irq    ext   timer     soft      epc       exp_pc
csr 1 340 12345678 00000000 0
csr 2 340 0000f000 12345678 0
csr 3 340 00000078 1234f678 0
csr 2 340 00000000 1234f600 0
csr 1 305 00000100 00000000 0
csr 2 305 00002000 00000100 0
csr 3 305 00000100 00002100 0
csr 2 305 00000000 00002000 0
csr 2 7c0 00000000 00000000 1
csr 1 344 00000001 00000000 1
csr 2 340 00000000 1234f600 0
# PMP entry 0 RWX below RAM, entry 1 read only over the first 32 KiB of RAM
csr 1 3a0 0000090f 00000000 0
csr 1 3b0 20000000 00000000 0
csr 1 3b1 20002000 00000000 0
access 2 10000000 2 0 0
access 2 10000000 0 1 2000
csr 2 342 00000000 00000007 0
csr 2 343 00000000 10000000 0
exc 0 00000444 00000000 2000 0
csr 2 342 00000000 0000000b 0
csr 2 341 00000000 00000444 0
csr 2 343 00000000 00000000 0
exc 1 00000448 00000000 2000 0
csr 2 342 00000000 00000003 0
csr 2 341 00000000 00000448 0
exc 2 0000044c 80000003 2000 0
csr 2 342 00000000 00000004 0
csr 2 341 00000000 0000044c 0
csr 2 343 00000000 80000003 0
# Drop to user mode
csr 1 300 00000000 00001800 0
csr 1 341 80000100 0000044c 0
ret 0 80000100 0 0 0
csr 1 340 deadbeef 00000000 1
ret 1 00000000 0 0 0
access 1 80000010 2 0 0
access 2 80000010 2 1 2000
csr 2 342 00000000 00000007 0
csr 2 343 00000000 80000010 0
csr 2 340 00000000 1234f600 0
csr 1 341 80000200 00000000 0
ret 0 80000200 0 0 0
access 1 80008000 2 1 2000
csr 2 342 00000000 00000005 0
csr 2 343 00000000 80008000 0
# Interrupt from user mode with MIE set
csr 1 304 00000880 00000000 0
csr 1 300 00000088 00000000 0
csr 1 341 80000300 00000000 0
ret 0 80000300 0 0 0
irq 1 1 0 80000304 2000
csr 2 342 00000000 8000000b 0
csr 2 341 00000000 80000304 0
ret 0 80000304 0 0 0
csr 2 340 00000000 00000000 1
